// ==== mgmt_io_defines.svh ====
`ifndef MGMT_IO_DEFINES_SVH
`define MGMT_IO_DEFINES_SVH

// Number of user pads in the daisy chain
// Pads 0 and 1 carry the JTAG and SDO overrides, so keep this at 2 or more
`define MGMT_IO_PADS 8

// Width of one pad configuration word
`define MGMT_CFG_BITS 5

// Bit positions inside a configuration word
// Pad owned by management when set
`define MGMT_CFG_MGMT_EN 0
// Output enable, active low
`define MGMT_CFG_OUT_ENB 1
// Input disable
`define MGMT_CFG_INP_DIS 2
// Low bit of the two bit drive mode field
`define MGMT_CFG_DM_LSB 3

// Power-up pad setup
// Drive mode 01, input on, output off, owned by management
`define MGMT_CFG_RESET 5'b01011

`endif

// ==== mgmt_io_pkg.sv ====
`include "mgmt_io_defines.svh"

package mgmt_io_pkg;

	// One pad configuration word as written by the host
	// Field layout is given by the MGMT_CFG_* positions
	typedef logic [`MGMT_CFG_BITS-1:0] cfg_word_t;

	// Pad drive mode, straight to the pad cell dm pins
	typedef logic [1:0] drive_mode_t;

	// Serial loader FSM
	// LD_IDLE waits for a write or an apply
	// LD_SHIFT pushes one word into the chain, MSB first
	// LD_LATCH copies every chain stage into its working register
	typedef enum logic [1:0] {
		LD_IDLE,
		LD_SHIFT,
		LD_LATCH
	} loader_state_t;

endpackage

// ==== io_config_loader.sv ====
`timescale 1ns/1ns
`include "mgmt_io_defines.svh"

module io_config_loader (
	input  logic                   clock_i,
	input  logic                   rst_n_i,
	input  logic                   cfg_wr_i,
	input  mgmt_io_pkg::cfg_word_t cfg_word_i,
	input  logic                   cfg_apply_i,
	output logic                   busy_o,
	output logic                   shift_o,
	output logic                   sdi_o,
	output logic                   latch_o
);
	import mgmt_io_pkg::*;

	loader_state_t state_q;
	loader_state_t state_d;
	// Counts shifted bits of the current word
	logic [$clog2(`MGMT_CFG_BITS)-1:0] bit_cnt_q;
	// Apply seen while shifting, issued once the word is out
	logic pend_apply_q;
	cfg_word_t shift_buf_q;
	logic last_bit;
	logic accept_wr;

	assign last_bit  = (bit_cnt_q == `MGMT_CFG_BITS - 1);
	// Writes are only taken outside the shift window
	assign accept_wr = cfg_wr_i && (state_q != LD_SHIFT);

	// Next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			LD_SHIFT: begin
				if (last_bit) begin
					// A deferred apply goes out right after the last bit
					state_d = (pend_apply_q || cfg_apply_i) ? LD_LATCH : LD_IDLE;
				end
			end
			LD_IDLE, LD_LATCH: begin
				if (cfg_wr_i) begin
					state_d = LD_SHIFT;
				end else if (cfg_apply_i) begin
					state_d = LD_LATCH;
				end else begin
					state_d = LD_IDLE;
				end
			end
			default: state_d = LD_IDLE;
		endcase
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q      <= LD_IDLE;
			bit_cnt_q    <= '0;
			pend_apply_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Free-runs only inside the shift window
			if (state_q == LD_SHIFT && !last_bit) begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
			end else begin
				bit_cnt_q <= '0;
			end
			if (state_q == LD_SHIFT) begin
				if (last_bit) begin
					pend_apply_q <= 1'b0;
				end else if (cfg_apply_i) begin
					pend_apply_q <= 1'b1;
				end
			end else begin
				// Apply together with a write waits for that write
				pend_apply_q <= cfg_wr_i && cfg_apply_i;
			end
		end
	end

	// Word buffer, MSB leaves first
	always_ff @(posedge clock_i) begin
		if (accept_wr) begin
			shift_buf_q <= cfg_word_i;
		end else if (state_q == LD_SHIFT) begin
			shift_buf_q <= {shift_buf_q[`MGMT_CFG_BITS-2:0], 1'b0};
		end
	end

	assign busy_o  = (state_q == LD_SHIFT);
	assign shift_o = (state_q == LD_SHIFT);
	assign sdi_o   = shift_buf_q[`MGMT_CFG_BITS-1];
	assign latch_o = (state_q == LD_LATCH);

	// Host must wait for busy_o to drop before the next write
	a_no_wr_while_busy: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		busy_o |-> !cfg_wr_i)
		else $error("config write issued while loader busy, word dropped");

	// One word is exactly one shift window
	a_shift_window: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		shift_o [*`MGMT_CFG_BITS] |=> !shift_o)
		else $error("shift enable held longer than one word");

	a_latch_not_shift: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!(latch_o && shift_o))
		else $error("latch pulse during chain shift");

endmodule

// ==== gpio_ctrl_block.sv ====
`timescale 1ns/1ns
`include "mgmt_io_defines.svh"

module gpio_ctrl_block (
	input  logic                     clock_i,
	input  logic                     rst_n_i,
	input  logic                     shift_i,
	input  logic                     sdi_i,
	input  logic                     latch_i,
	input  logic                     pad_in_i,
	input  logic                     mgmt_out_i,
	input  logic                     user_out_i,
	input  logic                     user_oeb_i,
	output logic                     sdo_o,
	output logic                     mgmt_en_o,
	output logic                     pad_out_o,
	output logic                     pad_oeb_o,
	output mgmt_io_pkg::drive_mode_t pad_dm_o,
	output logic                     mgmt_in_o,
	output logic                     user_in_o
);
	import mgmt_io_pkg::*;

	// Chain stage, loaded serially by the loader
	cfg_word_t shift_q;
	// Working configuration seen by the pad
	cfg_word_t cfg_q;
	logic out_enb;
	logic inp_dis;
	logic pad_in_gated;

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			shift_q <= `MGMT_CFG_RESET;
			cfg_q   <= `MGMT_CFG_RESET;
		end else begin
			if (shift_i) begin
				shift_q <= {shift_q[`MGMT_CFG_BITS-2:0], sdi_i};
			end
			// All pads take their chain word on the same edge
			if (latch_i) begin
				cfg_q <= shift_q;
			end
		end
	end

	// MSB moves on to the next pad
	assign sdo_o = shift_q[`MGMT_CFG_BITS-1];

	assign mgmt_en_o = cfg_q[`MGMT_CFG_MGMT_EN];
	assign out_enb   = cfg_q[`MGMT_CFG_OUT_ENB];
	assign inp_dis   = cfg_q[`MGMT_CFG_INP_DIS];

	// Input buffer off when inp_dis set
	assign pad_in_gated = pad_in_i && !inp_dis;

	// Ownership mux
	// Management drives through its own enable bit, user brings its own oeb
	assign pad_out_o = mgmt_en_o ? mgmt_out_i : user_out_i;
	assign pad_oeb_o = mgmt_en_o ? out_enb : user_oeb_i;

	// Only the owner sees the pad input
	assign mgmt_in_o = mgmt_en_o && pad_in_gated;
	assign user_in_o = !mgmt_en_o && pad_in_gated;

	// Drive mode follows the config whoever owns the pad
	assign pad_dm_o = cfg_q[`MGMT_CFG_DM_LSB +: $bits(drive_mode_t)];

	// Working config moves only on the edge that samples the latch pulse
	a_cfg_on_latch: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		$changed(cfg_q) |-> $past(latch_i))
		else $error("pad config changed without latch pulse");

endmodule

// ==== io_pad_collect.sv ====
`timescale 1ns/1ns
`include "mgmt_io_defines.svh"

module io_pad_collect (
	input  logic [`MGMT_IO_PADS-1:0] blk_out_i,
	input  logic [`MGMT_IO_PADS-1:0] blk_oeb_i,
	input  logic [`MGMT_IO_PADS-1:0] blk_mgmt_en_i,
	input  logic [`MGMT_IO_PADS-1:0] blk_mgmt_in_i,
	input  logic [`MGMT_IO_PADS-1:0] blk_user_in_i,
	input  logic [$bits(mgmt_io_pkg::drive_mode_t)*`MGMT_IO_PADS-1:0] blk_dm_i,
	input  logic                     sdo_pre_i,
	input  logic                     sdo_outenb_i,
	input  logic                     jtag_pre_i,
	output logic [`MGMT_IO_PADS-1:0] pad_out_o,
	output logic [`MGMT_IO_PADS-1:0] pad_oeb_o,
	output logic [$bits(mgmt_io_pkg::drive_mode_t)*`MGMT_IO_PADS-1:0] pad_dm_o,
	output logic [`MGMT_IO_PADS-1:0] mgmt_in_o,
	output logic [`MGMT_IO_PADS-1:0] user_in_o
);

	// Override when management owns the pad but left its output off
	logic sdo_ovr;
	logic jtag_ovr;

	assign sdo_ovr  = blk_mgmt_en_i[1] && blk_oeb_i[1];
	assign jtag_ovr = blk_mgmt_en_i[0] && blk_oeb_i[0];

	always_comb begin
		// Pads 2 and up go straight through
		pad_out_o = blk_out_i;
		pad_oeb_o = blk_oeb_i;

		// Pad 1 is the housekeeping SPI SDO by default
		if (sdo_ovr) begin
			pad_out_o[1] = sdo_pre_i;
			pad_oeb_o[1] = sdo_outenb_i;
		end

		// Pad 0 is JTAG, whose driver stays disabled for now
		if (jtag_ovr) begin
			pad_out_o[0] = jtag_pre_i;
			pad_oeb_o[0] = 1'b1;
		end
	end

	// Drive modes and routed inputs are not touched by the override
	assign pad_dm_o  = blk_dm_i;
	assign mgmt_in_o = blk_mgmt_in_i;
	assign user_in_o = blk_user_in_i;

endmodule

// ==== mgmt_io.sv ====
`timescale 1ns/1ns
`include "mgmt_io_defines.svh"

module mgmt_io (
	input  logic                     clock_i,
	input  logic                     rst_n_i,
	input  logic                     cfg_wr_i,
	input  mgmt_io_pkg::cfg_word_t   cfg_word_i,
	input  logic                     cfg_apply_i,
	input  logic [`MGMT_IO_PADS-1:0] pad_in_i,
	input  logic [`MGMT_IO_PADS-1:0] mgmt_out_i,
	input  logic [`MGMT_IO_PADS-1:0] user_out_i,
	input  logic [`MGMT_IO_PADS-1:0] user_oeb_i,
	input  logic                     sdo_pre_i,
	input  logic                     sdo_outenb_i,
	input  logic                     jtag_pre_i,
	output logic                     busy_o,
	output logic [`MGMT_IO_PADS-1:0] pad_out_o,
	output logic [`MGMT_IO_PADS-1:0] pad_oeb_o,
	output logic [$bits(mgmt_io_pkg::drive_mode_t)*`MGMT_IO_PADS-1:0] pad_dm_o,
	output logic [`MGMT_IO_PADS-1:0] mgmt_in_o,
	output logic [`MGMT_IO_PADS-1:0] user_in_o
);
	import mgmt_io_pkg::*;

	// Chain control, common to every pad
	logic chain_shift;
	logic chain_sdi;
	logic chain_latch;
	// Serial out of each pad, last one is the open end of the chain
	logic [`MGMT_IO_PADS-1:0] blk_sdo;

	logic [`MGMT_IO_PADS-1:0] blk_out;
	logic [`MGMT_IO_PADS-1:0] blk_oeb;
	logic [`MGMT_IO_PADS-1:0] blk_mgmt_en;
	logic [`MGMT_IO_PADS-1:0] blk_mgmt_in;
	logic [`MGMT_IO_PADS-1:0] blk_user_in;
	logic [$bits(drive_mode_t)*`MGMT_IO_PADS-1:0] blk_dm;

	io_config_loader u_loader (
		.clock_i     (clock_i),
		.rst_n_i     (rst_n_i),
		.cfg_wr_i    (cfg_wr_i),
		.cfg_word_i  (cfg_word_i),
		.cfg_apply_i (cfg_apply_i),
		.busy_o      (busy_o),
		.shift_o     (chain_shift),
		.sdi_o       (chain_sdi),
		.latch_o     (chain_latch)
	);

	// Pad 0 sits at the head of the chain
	for (genvar k = 0; k < `MGMT_IO_PADS; k++) begin : g_pad
		logic blk_sdi;

		if (k == 0) begin : g_head
			assign blk_sdi = chain_sdi;
		end else begin : g_link
			assign blk_sdi = blk_sdo[k-1];
		end

		gpio_ctrl_block u_blk (
			.clock_i    (clock_i),
			.rst_n_i    (rst_n_i),
			.shift_i    (chain_shift),
			.sdi_i      (blk_sdi),
			.latch_i    (chain_latch),
			.pad_in_i   (pad_in_i[k]),
			.mgmt_out_i (mgmt_out_i[k]),
			.user_out_i (user_out_i[k]),
			.user_oeb_i (user_oeb_i[k]),
			.sdo_o      (blk_sdo[k]),
			.mgmt_en_o  (blk_mgmt_en[k]),
			.pad_out_o  (blk_out[k]),
			.pad_oeb_o  (blk_oeb[k]),
			.pad_dm_o   (blk_dm[k*$bits(drive_mode_t) +: $bits(drive_mode_t)]),
			.mgmt_in_o  (blk_mgmt_in[k]),
			.user_in_o  (blk_user_in[k])
		);
	end

	io_pad_collect u_collect (
		.blk_out_i     (blk_out),
		.blk_oeb_i     (blk_oeb),
		.blk_mgmt_en_i (blk_mgmt_en),
		.blk_mgmt_in_i (blk_mgmt_in),
		.blk_user_in_i (blk_user_in),
		.blk_dm_i      (blk_dm),
		.sdo_pre_i     (sdo_pre_i),
		.sdo_outenb_i  (sdo_outenb_i),
		.jtag_pre_i    (jtag_pre_i),
		.pad_out_o     (pad_out_o),
		.pad_oeb_o     (pad_oeb_o),
		.pad_dm_o      (pad_dm_o),
		.mgmt_in_o     (mgmt_in_o),
		.user_in_o     (user_in_o)
	);

endmodule

// ==== tb_mgmt_io.sv ====
`timescale 1ns/1ns
`include "mgmt_io_defines.svh"

module tb_mgmt_io;
	import mgmt_io_pkg::*;

	localparam int N = `MGMT_IO_PADS;
	localparam int DMW = $bits(drive_mode_t) * N;
	localparam int EXP_W = 4 * N + DMW;
	localparam logic [31:0] SEED = 32'h4a36_d830;
	// One write is the strobe, five shifts and the return to idle
	localparam int WR_CYC = 7;
	// Reset, two single writes, five table loads, five applies, data windows
	localparam int RUN_CYC = 8 + (2 + 5 * N) * WR_CYC + 5 * 4 + 100;
	localparam int TIMEOUT_CYC = 4 * RUN_CYC;

	logic clock_i;
	logic rst_n_i;
	logic cfg_wr_i;
	cfg_word_t cfg_word_i;
	logic cfg_apply_i;
	logic [N-1:0] pad_in_i;
	logic [N-1:0] mgmt_out_i;
	logic [N-1:0] user_out_i;
	logic [N-1:0] user_oeb_i;
	logic sdo_pre_i;
	logic sdo_outenb_i;
	logic jtag_pre_i;
	logic busy_o;
	logic [N-1:0] pad_out_o;
	logic [N-1:0] pad_oeb_o;
	logic [DMW-1:0] pad_dm_o;
	logic [N-1:0] mgmt_in_o;
	logic [N-1:0] user_in_o;

	// Working config the pads should hold, and the one being loaded
	cfg_word_t model_tbl [N];
	cfg_word_t pending_tbl [N];
	logic [31:0] word_lcg;
	logic [31:0] data_lcg;
	logic cmp_en;
	logic [EXP_W-1:0] exp_v;
	string test_name;
	int err_count;
	int err_at_start;
	int pass_cnt;
	int fail_cnt;
	int cycle_cnt;

	mgmt_io u_mgmt_io (
		.clock_i      (clock_i),
		.rst_n_i      (rst_n_i),
		.cfg_wr_i     (cfg_wr_i),
		.cfg_word_i   (cfg_word_i),
		.cfg_apply_i  (cfg_apply_i),
		.pad_in_i     (pad_in_i),
		.mgmt_out_i   (mgmt_out_i),
		.user_out_i   (user_out_i),
		.user_oeb_i   (user_oeb_i),
		.sdo_pre_i    (sdo_pre_i),
		.sdo_outenb_i (sdo_outenb_i),
		.jtag_pre_i   (jtag_pre_i),
		.busy_o       (busy_o),
		.pad_out_o    (pad_out_o),
		.pad_oeb_o    (pad_oeb_o),
		.pad_dm_o     (pad_dm_o),
		.mgmt_in_o    (mgmt_in_o),
		.user_in_o    (user_in_o)
	);

	always #10 clock_i = ~clock_i;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected pad and input buses, packed as {out, oeb, dm, mgmt_in, user_in}
	function automatic logic [EXP_W-1:0] expected_outputs(
		input logic [N-1:0] pin,
		input logic [N-1:0] mout,
		input logic [N-1:0] uout,
		input logic [N-1:0] uoeb,
		input logic sdo,
		input logic sdo_oeb,
		input logic jtag
	);
		logic [N-1:0] e_out;
		logic [N-1:0] e_oeb;
		logic [N-1:0] e_min;
		logic [N-1:0] e_uin;
		logic [DMW-1:0] e_dm;
		cfg_word_t w;
		logic in_ok;
		for (int k = 0; k < N; k++) begin
			w = model_tbl[k];
			in_ok = pin[k] && !w[`MGMT_CFG_INP_DIS];
			e_dm[k*2 +: 2] = w[`MGMT_CFG_DM_LSB +: 2];
			if (w[`MGMT_CFG_MGMT_EN]) begin
				e_out[k] = mout[k];
				e_oeb[k] = w[`MGMT_CFG_OUT_ENB];
				e_min[k] = in_ok;
				e_uin[k] = 1'b0;
			end else begin
				e_out[k] = uout[k];
				e_oeb[k] = uoeb[k];
				e_min[k] = 1'b0;
				e_uin[k] = in_ok;
			end
			// Management pad with its output off hands the pad to SDO or JTAG
			if (k == 1 && w[`MGMT_CFG_MGMT_EN] && e_oeb[k]) begin
				e_out[k] = sdo;
				e_oeb[k] = sdo_oeb;
			end
			if (k == 0 && w[`MGMT_CFG_MGMT_EN] && e_oeb[k]) begin
				e_out[k] = jtag;
				e_oeb[k] = 1'b1;
			end
		end
		return {e_out, e_oeb, e_dm, e_min, e_uin};
	endfunction

	task automatic check_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			err_count++;
			$display("ERR %s: expected %h, actual %h", what, expected, actual);
		end
	endtask

	// Random pad and data inputs, new values every cycle
	always @(posedge clock_i) begin
		data_lcg = lcg_next(data_lcg);
		pad_in_i <= data_lcg[31 -: N];
		data_lcg = lcg_next(data_lcg);
		mgmt_out_i <= data_lcg[31 -: N];
		data_lcg = lcg_next(data_lcg);
		user_out_i <= data_lcg[31 -: N];
		data_lcg = lcg_next(data_lcg);
		user_oeb_i <= data_lcg[31 -: N];
		data_lcg = lcg_next(data_lcg);
		sdo_pre_i <= data_lcg[31];
		sdo_outenb_i <= data_lcg[30];
		jtag_pre_i <= data_lcg[29];
	end

	// Outputs settle between edges, so compare on the falling edge
	always @(negedge clock_i) begin
		if (cmp_en) begin
			exp_v = expected_outputs(pad_in_i, mgmt_out_i, user_out_i, user_oeb_i,
				sdo_pre_i, sdo_outenb_i, jtag_pre_i);
			check_value({test_name, " pad_out_o"}, 64'(exp_v[EXP_W-1 -: N]), 64'(pad_out_o));
			check_value({test_name, " pad_oeb_o"}, 64'(exp_v[EXP_W-N-1 -: N]), 64'(pad_oeb_o));
			check_value({test_name, " pad_dm_o"}, 64'(exp_v[2*N +: DMW]), 64'(pad_dm_o));
			check_value({test_name, " mgmt_in_o"}, 64'(exp_v[N +: N]), 64'(mgmt_in_o));
			check_value({test_name, " user_in_o"}, 64'(exp_v[N-1:0]), 64'(user_in_o));
		end
	end

	always @(posedge clock_i) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYC);
			$display("Simulation failed");
			$finish;
		end
	end

	task wait_cycles(input int n);
		repeat (n) @(posedge clock_i);
	endtask

	task start_test(input string name);
		test_name = name;
		err_at_start = err_count;
	endtask

	task end_test();
		if (err_count == err_at_start) begin
			pass_cnt++;
			$display("Test %s: ok", test_name);
		end else begin
			fail_cnt++;
			$display("Test %s: FAILED with %0d mismatches", test_name, err_count - err_at_start);
		end
	endtask

	task fill_random_table();
		for (int k = 0; k < N; k++) begin
			word_lcg = lcg_next(word_lcg);
			pending_tbl[k] = word_lcg[31 -: `MGMT_CFG_BITS];
		end
	endtask

	// Starts and ends just after a rising edge, busy counted on falling edges
	task write_word(input cfg_word_t w);
		int busy_cycles;
		busy_cycles = 0;
		cfg_wr_i <= 1'b1;
		cfg_word_i <= w;
		@(posedge clock_i);
		cfg_wr_i <= 1'b0;
		@(negedge clock_i);
		while (busy_o) begin
			busy_cycles++;
			@(negedge clock_i);
		end
		check_value({test_name, " busy cycles"}, 64'(`MGMT_CFG_BITS), 64'(busy_cycles));
		@(posedge clock_i);
	endtask

	// First word written travels to the far end of the chain
	task load_table();
		for (int i = 0; i < N; i++) begin
			write_word(pending_tbl[N-1-i]);
		end
	endtask

	task apply_table();
		cfg_apply_i <= 1'b1;
		@(posedge clock_i);
		cfg_apply_i <= 1'b0;
		// Latch pulse this cycle, working config moves on the next edge
		@(posedge clock_i);
		for (int k = 0; k < N; k++) begin
			model_tbl[k] = pending_tbl[k];
		end
	endtask

	// Pads 0 and 1 owned by management, output on or off
	task override_phase(input logic enb);
		fill_random_table();
		for (int k = 0; k < 2; k++) begin
			pending_tbl[k][`MGMT_CFG_MGMT_EN] = 1'b1;
			pending_tbl[k][`MGMT_CFG_OUT_ENB] = enb;
		end
		load_table();
		apply_table();
		wait_cycles(2);
		@(negedge clock_i);
		if (enb) begin
			check_value({test_name, " pad0 jtag"}, 64'(jtag_pre_i), 64'(pad_out_o[0]));
			check_value({test_name, " pad0 oeb"}, 64'(1), 64'(pad_oeb_o[0]));
			check_value({test_name, " pad1 sdo"}, 64'(sdo_pre_i), 64'(pad_out_o[1]));
			check_value({test_name, " pad1 oeb"}, 64'(sdo_outenb_i), 64'(pad_oeb_o[1]));
		end else begin
			check_value({test_name, " pad0 mgmt"}, 64'(mgmt_out_i[0]), 64'(pad_out_o[0]));
			check_value({test_name, " pad0 oeb"}, 64'(0), 64'(pad_oeb_o[0]));
			check_value({test_name, " pad1 mgmt"}, 64'(mgmt_out_i[1]), 64'(pad_out_o[1]));
			check_value({test_name, " pad1 oeb"}, 64'(0), 64'(pad_oeb_o[1]));
		end
		@(posedge clock_i);
		wait_cycles(4);
	endtask

	initial begin
		clock_i = 1'b0;
		rst_n_i = 1'b0;
		cfg_wr_i = 1'b0;
		cfg_word_i = '0;
		cfg_apply_i = 1'b0;
		pad_in_i = '0;
		mgmt_out_i = '0;
		user_out_i = '0;
		user_oeb_i = '0;
		sdo_pre_i = 1'b0;
		sdo_outenb_i = 1'b0;
		jtag_pre_i = 1'b0;
		word_lcg = SEED;
		data_lcg = SEED;
		cmp_en = 1'b0;
		test_name = "none";
		err_count = 0;
		err_at_start = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		cycle_cnt = 0;
		for (int k = 0; k < N; k++) begin
			model_tbl[k] = `MGMT_CFG_RESET;
		end
		repeat (8) @(posedge clock_i);
		rst_n_i <= 1'b1;
		cmp_en = 1'b1;

		start_test("reset_defaults");
		wait_cycles(4);
		@(negedge clock_i);
		check_value({test_name, " busy_o"}, 64'(0), 64'(busy_o));
		@(posedge clock_i);
		end_test();

		start_test("busy_timing");
		fill_random_table();
		write_word(pending_tbl[0]);
		write_word(pending_tbl[1]);
		end_test();

		start_test("chain_order_apply");
		fill_random_table();
		load_table();
		apply_table();
		wait_cycles(8);
		end_test();

		// Old table must hold through a full reload
		start_test("hold_until_apply");
		fill_random_table();
		load_table();
		wait_cycles(8);
		apply_table();
		wait_cycles(4);
		end_test();

		// Alternate owners so both routing paths see random data
		start_test("ownership_gating");
		fill_random_table();
		for (int k = 0; k < N; k++) begin
			pending_tbl[k][`MGMT_CFG_MGMT_EN] = (k % 2 == 1);
		end
		load_table();
		apply_table();
		wait_cycles(50);
		end_test();

		start_test("override");
		override_phase(1'b0);
		override_phase(1'b1);
		end_test();

		$display("Totals: %0d tests ok, %0d tests failed, %0d mismatches",
			pass_cnt, fail_cnt, err_count);
		if (fail_cnt == 0 && err_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
mgmt_io_pkg.sv
io_config_loader.sv
gpio_ctrl_block.sv
io_pad_collect.sv
mgmt_io.sv
tb_mgmt_io.sv

// ==== Makefile ====
# Verilator build and run for the management I/O configuration path

VERILATOR ?= verilator
TOP       ?= tb_mgmt_io
RTL_TOP   ?= mgmt_io
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
